// File: sim/nurnCore_golden.txt
// per test: cfg rstPot thMask inSpike / bias0-3 pot0-3 th0-3 / weights n0..n3 (8 each)
// then expected: outSpike pot0-3 th0-3, all 16-bit hex, 8.8 fixed point
// test 0 integrate and fire
0000 0000 0000 000F
0000 0080 0000 FF00 0000 0100 0000 0200 0300 0800 0100 0100
0100 0100 0100 0100 0100 0100 0100 0100
0040 0040 0040 0040 0040 0040 0040 0040
0020 0020 0020 0020 0400 0400 0400 0400
0000 0000 0000 0000 0000 0000 0000 0000
0009 0000 0280 0080 0000 0300 0800 0100 0100
// test 1 relu
0001 0000 0000 00FF
0000 FF80 0100 0000 0000 0000 0100 0000 0200 0100 0100 7F00
0040 0040 0040 0040 0040 0040 0040 0040
0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000
0010 0010 0010 0010 0010 0010 0010 0010
0005 0200 FF80 0200 0080 0200 0100 0100 7F00
// test 2 saturation
0001 0000 0000 00FF
4000 7000 8000 3000 4000 0000 C000 0000 7FFF 7FFF 0000 8000
4000 4000 4000 4000 4000 4000 4000 4000
1000 1000 1000 1000 1000 1000 1000 1000
0000 0000 0000 0000 0000 0000 0000 0000
1000 1000 1000 1000 1000 1000 1000 1000
000B 7FFF 7FFF 8000 7FFF 7FFF 7FFF 0000 8000
// test 3 random threshold
0002 0010 00FF 0001
0000 0000 0100 0000 0000 0000 0000 0000 0100 0100 0080 FFF0
0200 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000
000D 0010 0000 0010 0010 0170 0100 00B8 FFFF

// File: nurnCore.f
verilog/nurnPkg.sv
verilog/lfsr.sv
verilog/statusMem.sv
verilog/dataPath.sv
verilog/nurnCtrl.sv
verilog/axilCfg.sv
verilog/nurnCore.sv
sim/nurnCore_props.sv
sim/tb_nurnCore.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_nurnCore
FILELIST = nurnCore.f
LOG      = sim.log
RUNARGS  = +verilator+error+limit+100

.PHONY: simulate clean

simulate:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o V$(TOP)
	-./obj_dir/V$(TOP) $(RUNARGS) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "\*\*\* TEST PASSED \*\*\*" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: sim/tb_nurnCore.sv
//------------------------------------------------------------
// tb_nurnCore
// testbench for the recall core, AXI4-Lite register checks
// and timesteps replayed from the golden data file
//------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module tb_nurnCore
	import nurnPkg::*;
();

	localparam int CLK_PERIOD = 100;
	localparam int RST_CYCLES = 8;
	localparam int NUM_TESTS  = 4;
	localparam int STEP_CYCLES = NUM_NURNS * (NUM_AXONS + 7) + 1;
	// register test counts as one more test
	localparam int WATCHDOG_CYCLES = (NUM_TESTS + 1) * (STEP_CYCLES + 200);

	// record layout of one test in the golden file
	localparam int OFS_CFG    = 0;
	localparam int OFS_RSTPOT = 1;
	localparam int OFS_THMASK = 2;
	localparam int OFS_INSPK  = 3;
	localparam int OFS_BIAS   = 4;
	localparam int OFS_POT    = 8;
	localparam int OFS_TH     = 12;
	localparam int OFS_WT     = 16;
	localparam int OFS_EXPOUT = 48;
	localparam int OFS_EXPPOT = 49;
	localparam int OFS_EXPTH  = 53;
	localparam int REC_LEN    = 57;

	logic              clk_i;
	logic              rst_n_i;
	logic [AXI_AW-1:0] awaddr_i;
	logic              awvalid_i;
	logic              awready_o;
	logic [AXI_DW-1:0] wdata_i;
	logic              wvalid_i;
	logic              wready_o;
	logic [1:0]        bresp_o;
	logic              bvalid_o;
	logic              bready_i;
	logic [AXI_AW-1:0] araddr_i;
	logic              arvalid_i;
	logic              arready_o;
	logic [AXI_DW-1:0] rdata_o;
	logic [1:0]        rresp_o;
	logic              rvalid_o;
	logic              rready_i;
	logic              outSpike_o;
	logic [NURN_W-1:0] spikeNurn_o;
	logic              done_o;

	logic [DATA_W-1:0]    golden [NUM_TESTS*REC_LEN];
	logic [NUM_NURNS-1:0] seenSpikes;
	int                   checks;
	int                   errors;
	int                   testErrors;
	int                   seed = 32'ha49ea66d;
	string                testNames [NUM_TESTS];

	nurnCore DUT (.*);

	initial begin
		clk_i = 1'b0;
		forever #(CLK_PERIOD/2) clk_i = ~clk_i;
	end

	// random back-pressure on the B and R channels
	initial begin
		bready_i <= 1'b1;
		rready_i <= 1'b1;
		forever begin
			@(posedge clk_i);
			bready_i <= ($random(seed) & 3) != 0;
			rready_i <= ($random(seed) & 3) != 0;
		end
	end

	// spike pulses as seen on the outputs
	always @(negedge clk_i) begin
		if (rst_n_i && outSpike_o) begin
			seenSpikes[spikeNurn_o] = 1'b1;
		end
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("watchdog expired after %0d cycles, the run did not complete", WATCHDOG_CYCLES);
		$display("*** TEST FAILED ***");
		$finish;
	end

	//--------------------------------------------------------
	// helpers
	//--------------------------------------------------------
	task automatic checkValue(input string name, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		if (exp !== act) begin
			errors++;
			testErrors++;
			$display("Error at %0t ns: %s expected 0x%h, got 0x%h", $time, name, exp, act);
		end
	endtask

	task automatic applyReset();
		@(posedge clk_i);
		rst_n_i <= 1'b0;
		repeat (RST_CYCLES) @(posedge clk_i);
		rst_n_i <= 1'b1;
	endtask

	function automatic logic [AXI_AW-1:0] memAddr(input int nurn, input int slot);
		return MEM_BASE + AXI_AW'((nurn * 16 + slot) * 4);
	endfunction

	task automatic axiWrite(input logic [AXI_AW-1:0] addr, input logic [31:0] data,
		output logic [1:0] resp);
		@(posedge clk_i);
		awaddr_i  <= addr;
		wdata_i   <= data;
		awvalid_i <= 1'b1;
		wvalid_i  <= 1'b1;
		@(negedge clk_i);
		while (!(awready_o && wready_o)) @(negedge clk_i);
		@(posedge clk_i);
		awvalid_i <= 1'b0;
		wvalid_i  <= 1'b0;
		@(negedge clk_i);
		// response transfers on the next rising edge
		while (!(bvalid_o && bready_i)) @(negedge clk_i);
		resp = bresp_o;
	endtask

	task automatic axiRead(input logic [AXI_AW-1:0] addr, output logic [31:0] data,
		output logic [1:0] resp);
		@(posedge clk_i);
		araddr_i  <= addr;
		arvalid_i <= 1'b1;
		@(negedge clk_i);
		while (!arready_o) @(negedge clk_i);
		@(posedge clk_i);
		arvalid_i <= 1'b0;
		@(negedge clk_i);
		while (!(rvalid_o && rready_i)) @(negedge clk_i);
		data = rdata_o;
		resp = rresp_o;
	endtask

	task automatic writeChecked(input logic [AXI_AW-1:0] addr, input logic [31:0] data,
		input logic [1:0] expResp, input string name);
		logic [1:0] resp;
		axiWrite(addr, data, resp);
		checkValue({"bresp ", name}, expResp, resp);
	endtask

	task automatic readChecked(input logic [AXI_AW-1:0] addr, input logic [31:0] exp,
		input string name);
		logic [31:0] data;
		logic [1:0]  resp;
		axiRead(addr, data, resp);
		checkValue({"rresp ", name}, RESP_OKAY, resp);
		checkValue({"rdata ", name}, exp, data);
	endtask

	task automatic readResp(input logic [AXI_AW-1:0] addr, input logic [1:0] expResp,
		input string name);
		logic [31:0] data;
		logic [1:0]  resp;
		axiRead(addr, data, resp);
		checkValue({"rresp ", name}, expResp, resp);
	endtask

	//--------------------------------------------------------
	// tests
	//--------------------------------------------------------
	task automatic registerTest();
		testErrors = 0;
		writeChecked(REG_RSTPOT, 32'h1234, RESP_OKAY, "RSTPOT");
		writeChecked(REG_THMASK, 32'hBEEF, RESP_OKAY, "THMASK");
		writeChecked(REG_CFG, 32'h3, RESP_OKAY, "CFG");
		writeChecked(REG_INSPIKE, 32'h5A, RESP_OKAY, "INSPIKE");
		readChecked(REG_RSTPOT, 32'h1234, "RSTPOT");
		readChecked(REG_THMASK, 32'hBEEF, "THMASK");
		readChecked(REG_CFG, 32'h3, "CFG");
		readChecked(REG_INSPIKE, 32'h5A, "INSPIKE");
		// idle status memory is open to the host
		writeChecked(memAddr(3, 15), 32'hA5C3, RESP_OKAY, "mem idle");
		readChecked(memAddr(3, 15), 32'hA5C3, "mem idle");
		writeChecked(12'h020, 32'h1, RESP_SLVERR, "unmapped");
		readResp(12'h020, RESP_SLVERR, "unmapped");
		$display("test registers: %0d errors", testErrors);
	endtask

	task automatic goldenTest(input int t);
		int          base;
		int          n;
		int          a;
		logic [31:0] expOut;
		base = t * REC_LEN;
		testErrors = 0;
		applyReset();
		writeChecked(REG_CFG, 32'(golden[base+OFS_CFG]), RESP_OKAY, "CFG");
		writeChecked(REG_RSTPOT, 32'(golden[base+OFS_RSTPOT]), RESP_OKAY, "RSTPOT");
		writeChecked(REG_THMASK, 32'(golden[base+OFS_THMASK]), RESP_OKAY, "THMASK");
		writeChecked(REG_INSPIKE, 32'(golden[base+OFS_INSPK]), RESP_OKAY, "INSPIKE");
		for (n = 0; n < NUM_NURNS; n++) begin
			writeChecked(memAddr(n, SLOT_BIAS), 32'(golden[base+OFS_BIAS+n]), RESP_OKAY, "bias");
			writeChecked(memAddr(n, SLOT_POT), 32'(golden[base+OFS_POT+n]), RESP_OKAY, "pot");
			writeChecked(memAddr(n, SLOT_TH), 32'(golden[base+OFS_TH+n]), RESP_OKAY, "th");
			for (a = 0; a < NUM_AXONS; a++) begin
				writeChecked(memAddr(n, SLOT_WT + a), 32'(golden[base+OFS_WT+n*NUM_AXONS+a]),
					RESP_OKAY, "weight");
			end
		end
		seenSpikes = '0;

		writeChecked(REG_CTRL, 32'h1, RESP_OKAY, "start");
		readChecked(REG_CTRL, 32'h1, "CTRL busy");
		// host is locked out of the memory while busy
		readResp(memAddr(0, SLOT_POT), RESP_SLVERR, "mem busy");
		writeChecked(memAddr(NUM_NURNS-1, SLOT_BIAS), 32'h5555, RESP_SLVERR, "mem busy");
		@(negedge clk_i);
		while (!done_o) @(negedge clk_i);
		readChecked(REG_CTRL, 32'h2, "CTRL done");

		// the refused write left the bias alone
		readChecked(memAddr(NUM_NURNS-1, SLOT_BIAS), 32'(golden[base+OFS_BIAS+NUM_NURNS-1]),
			"bias after busy write");

		expOut = 32'(golden[base+OFS_EXPOUT]);
		checkValue("outSpike_o pulses", expOut, 32'(seenSpikes));
		readChecked(REG_OUTSPIKE, expOut, "OUTSPIKE");
		for (n = 0; n < NUM_NURNS; n++) begin
			readChecked(memAddr(n, SLOT_POT), 32'(golden[base+OFS_EXPPOT+n]),
				$sformatf("pot n%0d", n));
			readChecked(memAddr(n, SLOT_TH), 32'(golden[base+OFS_EXPTH+n]),
				$sformatf("th n%0d", n));
		end
		$display("test %0d %s: %0d errors", t, testNames[t], testErrors);
	endtask

	initial begin
		int t;
		rst_n_i   <= 1'b0;
		awaddr_i  <= '0;
		awvalid_i <= 1'b0;
		wdata_i   <= '0;
		wvalid_i  <= 1'b0;
		araddr_i  <= '0;
		arvalid_i <= 1'b0;
		seenSpikes = '0;
		checks = 0;
		errors = 0;
		testNames[0] = "integrate and fire";
		testNames[1] = "relu";
		testNames[2] = "saturation";
		testNames[3] = "random threshold";
		$readmemh("sim/nurnCore_golden.txt", golden);

		applyReset();
		registerTest();
		for (t = 0; t < NUM_TESTS; t++) begin
			goldenTest(t);
		end

		$display("tests %0d, checks %0d, errors %0d, assertion failures %0d",
			NUM_TESTS + 1, checks, errors, DUT.u_props.failCount);
		if (errors == 0 && DUT.u_props.failCount == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: sim/nurnCore_props.sv
//------------------------------------------------------------
// nurnCore_props
// handshake, spike pulse and timestep length assertions
//------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module nurnCore_props
	import nurnPkg::*;
(
	input wire logic clk_i,
	input wire logic rst_n_i,
	input wire logic awvalid_i,
	input wire logic awready_o,
	input wire logic arvalid_i,
	input wire logic arready_o,
	input wire logic bvalid_o,
	input wire logic bready_i,
	input wire logic rvalid_o,
	input wire logic rready_i,
	input wire logic outSpike_o,
	input wire logic done_o,
	input wire logic start_i
);

	int failCount = 0;

	awHold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		awvalid_i && !awready_o |=> awvalid_i)
		else begin
			$error("awvalid dropped before awready");
			failCount = failCount + 1;
		end

	arHold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		arvalid_i && !arready_o |=> arvalid_i)
		else begin
			$error("arvalid dropped before arready");
			failCount = failCount + 1;
		end

	bHold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		bvalid_o && !bready_i |=> bvalid_o)
		else begin
			$error("bvalid dropped before bready");
			failCount = failCount + 1;
		end

	rHold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		rvalid_o && !rready_i |=> rvalid_o)
		else begin
			$error("rvalid dropped before rready");
			failCount = failCount + 1;
		end

	// spike is a single-cycle pulse
	spikePulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		outSpike_o |=> !outSpike_o)
		else begin
			$error("outSpike_o longer than one cycle");
			failCount = failCount + 1;
		end

	doneTime: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		start_i |-> ##61 done_o)
		else begin
			$error("done_o not 61 cycles after start");
			failCount = failCount + 1;
		end

endmodule

bind nurnCore nurnCore_props u_props (
	.clk_i(clk_i), .rst_n_i(rst_n_i),
	.awvalid_i(awvalid_i), .awready_o(awready_o),
	.arvalid_i(arvalid_i), .arready_o(arready_o),
	.bvalid_o(bvalid_o), .bready_i(bready_i),
	.rvalid_o(rvalid_o), .rready_i(rready_i),
	.outSpike_o(outSpike_o), .done_o(done_o), .start_i(start)
);

`default_nettype wire

// File: verilog/nurnCore.sv
//------------------------------------------------------------
// nurnCore
// recall core top level, AXI4-Lite in, spike events out
//------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module nurnCore
	import nurnPkg::*;
(
	input  wire logic              clk_i,
	input  wire logic              rst_n_i,
	input  wire logic [AXI_AW-1:0] awaddr_i,
	input  wire logic              awvalid_i,
	output logic                   awready_o,
	input  wire logic [AXI_DW-1:0] wdata_i,
	input  wire logic              wvalid_i,
	output logic                   wready_o,
	output logic      [1:0]        bresp_o,
	output logic                   bvalid_o,
	input  wire logic              bready_i,
	input  wire logic [AXI_AW-1:0] araddr_i,
	input  wire logic              arvalid_i,
	output logic                   arready_o,
	output logic      [AXI_DW-1:0] rdata_o,
	output logic      [1:0]        rresp_o,
	output logic                   rvalid_o,
	input  wire logic              rready_i,
	output logic                   outSpike_o,
	output logic      [NURN_W-1:0] spikeNurn_o,
	output logic                   done_o
);

	logic                 busy;
	logic                 start;
	logic                 nurnType;
	logic                 randTh;
	logic [DATA_W-1:0]    rstPot;
	logic [DATA_W-1:0]    thMask;
	logic [NUM_AXONS-1:0] inSpike;
	logic [MEM_AW-1:0]    hostAddr;
	logic [DATA_W-1:0]    hostWData;
	logic                 hostWe;
	logic [NURN_W-1:0]    nurn;
	logic [MEM_AW-1:0]    ctrlRdAddr;
	logic [MEM_AW-1:0]    ctrlWrAddr;
	logic                 ctrlWe;
	logic                 accClr;
	logic                 accEn;
	rclSel_e              rclSel;
	logic                 cmpTh;
	wrSel_e               wrSel;
	logic                 rclSpike;
	logic [DATA_W-1:0]    dpWrData;
	logic [DATA_W-1:0]    memRdData;
	logic [DATA_W-1:0]    lfsrData;
	logic                 rdLfsr;

	// controller owns the memory while busy, the host otherwise
	logic [MEM_AW-1:0] memRdAddr;
	logic [MEM_AW-1:0] memWrAddr;
	logic [DATA_W-1:0] memWrData;
	logic              memWe;

	assign memRdAddr = busy ? ctrlRdAddr : hostAddr;
	assign memWrAddr = busy ? ctrlWrAddr : hostAddr;
	assign memWrData = busy ? dpWrData : hostWData;
	assign memWe     = busy ? ctrlWe : hostWe;

	axilCfg u_axilCfg (
		.clk_i(clk_i), .rst_n_i(rst_n_i),
		.awaddr_i(awaddr_i), .awvalid_i(awvalid_i), .awready_o(awready_o),
		.wdata_i(wdata_i), .wvalid_i(wvalid_i), .wready_o(wready_o),
		.bresp_o(bresp_o), .bvalid_o(bvalid_o), .bready_i(bready_i),
		.araddr_i(araddr_i), .arvalid_i(arvalid_i), .arready_o(arready_o),
		.rdata_o(rdata_o), .rresp_o(rresp_o), .rvalid_o(rvalid_o), .rready_i(rready_i),
		.busy_i(busy), .spikeValid_i(outSpike_o), .spikeNurn_i(spikeNurn_o),
		.memRdData_i(memRdData), .start_o(start), .nurnType_o(nurnType),
		.randTh_o(randTh), .rstPot_o(rstPot), .thMask_o(thMask), .inSpike_o(inSpike),
		.hostAddr_o(hostAddr), .hostWData_o(hostWData), .hostWe_o(hostWe)
	);

	nurnCtrl u_nurnCtrl (
		.clk_i(clk_i), .rst_n_i(rst_n_i), .start_i(start), .inSpike_i(inSpike),
		.busy_o(busy), .done_o(done_o), .nurn_o(nurn),
		.rdAddr_o(ctrlRdAddr), .wrAddr_o(ctrlWrAddr), .memWe_o(ctrlWe),
		.accClr_o(accClr), .accEn_o(accEn), .rclSel_o(rclSel), .cmpTh_o(cmpTh),
		.wrSel_o(wrSel), .rclSpike_o(rclSpike)
	);

	dataPath u_dataPath (
		.clk_i(clk_i), .rst_n_i(rst_n_i), .rdData_i(memRdData),
		.nurnType_i(nurnType), .randTh_i(randTh), .rstPot_i(rstPot), .thMask_i(thMask),
		.lfsrData_i(lfsrData), .accClr_i(accClr), .accEn_i(accEn), .rclSel_i(rclSel),
		.rclSpike_i(rclSpike), .cmpTh_i(cmpTh), .wrSel_i(wrSel), .nurn_i(nurn),
		.wrData_o(dpWrData), .outSpike_o(outSpike_o), .spikeNurn_o(spikeNurn_o),
		.rdLfsr_o(rdLfsr)
	);

	statusMem u_statusMem (
		.clk_i(clk_i), .rdAddr_i(memRdAddr), .wrAddr_i(memWrAddr),
		.wrData_i(memWrData), .we_i(memWe), .rdData_o(memRdData)
	);

	lfsr u_lfsr (
		.clk_i(clk_i), .rst_n_i(rst_n_i), .adv_i(rdLfsr), .data_o(lfsrData)
	);

endmodule

`default_nettype wire

// File: verilog/axilCfg.sv
//------------------------------------------------------------
// axilCfg
// AXI4-Lite slave with configuration, spike and status
// registers plus host access to the status memory
//------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module axilCfg
	import nurnPkg::*;
(
	input  wire logic                 clk_i,
	input  wire logic                 rst_n_i,
	input  wire logic [AXI_AW-1:0]    awaddr_i,
	input  wire logic                 awvalid_i,
	output logic                      awready_o,
	input  wire logic [AXI_DW-1:0]    wdata_i,
	input  wire logic                 wvalid_i,
	output logic                      wready_o,
	output logic      [1:0]           bresp_o,
	output logic                      bvalid_o,
	input  wire logic                 bready_i,
	input  wire logic [AXI_AW-1:0]    araddr_i,
	input  wire logic                 arvalid_i,
	output logic                      arready_o,
	output logic      [AXI_DW-1:0]    rdata_o,
	output logic      [1:0]           rresp_o,
	output logic                      rvalid_o,
	input  wire logic                 rready_i,
	input  wire logic                 busy_i,
	input  wire logic                 spikeValid_i,
	input  wire logic [NURN_W-1:0]    spikeNurn_i,
	input  wire logic [DATA_W-1:0]    memRdData_i,
	output logic                      start_o,
	output logic                      nurnType_o,
	output logic                      randTh_o,
	output logic      [DATA_W-1:0]    rstPot_o,
	output logic      [DATA_W-1:0]    thMask_o,
	output logic      [NUM_AXONS-1:0] inSpike_o,
	output logic      [MEM_AW-1:0]    hostAddr_o,
	output logic      [DATA_W-1:0]    hostWData_o,
	output logic                      hostWe_o
);

	logic                 rstDone;
	logic                 wrAcc;
	logic                 rdAcc;
	logic                 awMem;
	logic                 arMem;
	logic                 rdPend;
	logic                 rdHit;
	logic [AXI_DW-1:0]    regRdData;
	logic                 doneR;
	logic                 busyDly;
	logic [NUM_NURNS-1:0] outSpikeR;

	//--------------------------------------------------------
	// handshakes
	//--------------------------------------------------------
	// AW and W only transfer together, one write at a time
	assign wrAcc     = rstDone & ~bvalid_o & awvalid_i & wvalid_i;
	assign awready_o = wrAcc;
	assign wready_o  = wrAcc;

	// a write in the same cycle owns the host address
	assign rdAcc     = rstDone & ~rvalid_o & ~rdPend & arvalid_i & ~wrAcc;
	assign arready_o = rdAcc;

	assign awMem = awaddr_i[AXI_AW-1:8] == MEM_BASE[AXI_AW-1:8];
	assign arMem = araddr_i[AXI_AW-1:8] == MEM_BASE[AXI_AW-1:8];

	// host side of the status memory
	assign hostAddr_o  = wrAcc ? awaddr_i[MEM_AW+1:2] : araddr_i[MEM_AW+1:2];
	assign hostWData_o = wdata_i[DATA_W-1:0];
	assign hostWe_o    = wrAcc & awMem & ~busy_i;

	// register read mux
	always_comb begin
		regRdData = '0;
		rdHit     = 1'b1;
		case (araddr_i)
			REG_CTRL:     regRdData[1:0]           = {doneR, busy_i};
			REG_CFG:      regRdData[1:0]           = {randTh_o, nurnType_o};
			REG_RSTPOT:   regRdData[DATA_W-1:0]    = rstPot_o;
			REG_THMASK:   regRdData[DATA_W-1:0]    = thMask_o;
			REG_INSPIKE:  regRdData[NUM_AXONS-1:0] = inSpike_o;
			REG_OUTSPIKE: regRdData[NUM_NURNS-1:0] = outSpikeR;
			default:      rdHit = 1'b0;
		endcase
	end

	//--------------------------------------------------------
	// registers and channel state
	//--------------------------------------------------------
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			rstDone    <= 1'b0;
			bvalid_o   <= 1'b0;
			bresp_o    <= RESP_OKAY;
			rvalid_o   <= 1'b0;
			rresp_o    <= RESP_OKAY;
			rdPend     <= 1'b0;
			start_o    <= 1'b0;
			nurnType_o <= 1'b0;
			randTh_o   <= 1'b0;
			rstPot_o   <= '0;
			thMask_o   <= '0;
			inSpike_o  <= '0;
			doneR      <= 1'b0;
			busyDly    <= 1'b0;
			outSpikeR  <= '0;
		end else begin
			rstDone <= 1'b1;
			start_o <= 1'b0;
			busyDly <= busy_i;

			// write channel
			if (bvalid_o && bready_i) begin
				bvalid_o <= 1'b0;
			end
			if (wrAcc) begin
				bvalid_o <= 1'b1;
				bresp_o  <= RESP_OKAY;
				if (awMem) begin
					if (busy_i) begin
						bresp_o <= RESP_SLVERR;
					end
				end else begin
					case (awaddr_i)
						// start while busy is dropped
						REG_CTRL:    start_o   <= wdata_i[0] & ~busy_i;
						REG_CFG: begin
							nurnType_o <= wdata_i[0];
							randTh_o   <= wdata_i[1];
						end
						REG_RSTPOT:  rstPot_o  <= wdata_i[DATA_W-1:0];
						REG_THMASK:  thMask_o  <= wdata_i[DATA_W-1:0];
						REG_INSPIKE: inSpike_o <= wdata_i[NUM_AXONS-1:0];
						default:     bresp_o   <= RESP_SLVERR;
					endcase
				end
			end

			// read channel, memory reads take one extra cycle
			if (rvalid_o && rready_i) begin
				rvalid_o <= 1'b0;
			end
			rdPend <= 1'b0;
			if (rdPend) begin
				rvalid_o <= 1'b1;
				rresp_o  <= RESP_OKAY;
			end
			if (rdAcc) begin
				if (arMem && !busy_i) begin
					rdPend <= 1'b1;
				end else begin
					rvalid_o <= 1'b1;
					rresp_o  <= (rdHit && !arMem) ? RESP_OKAY : RESP_SLVERR;
				end
			end

			// done is sticky until the next start
			if (start_o) begin
				doneR     <= 1'b0;
				outSpikeR <= '0;
			end else begin
				if (busyDly && !busy_i) begin
					doneR <= 1'b1;
				end
				if (spikeValid_i) begin
					outSpikeR[spikeNurn_i] <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (rdPend) begin
			rdata_o <= AXI_DW'(memRdData_i);
		end else if (rdAcc) begin
			rdata_o <= regRdData;
		end
	end

endmodule

`default_nettype wire

// File: verilog/nurnCtrl.sv
//------------------------------------------------------------
// nurnCtrl
// sequences neurons and axons through one timestep and drives
// the data-path selects and status-memory addresses
//------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module nurnCtrl
	import nurnPkg::*;
(
	input  wire logic                 clk_i,
	input  wire logic                 rst_n_i,
	input  wire logic                 start_i,
	input  wire logic [NUM_AXONS-1:0] inSpike_i,
	output logic                      busy_o,
	output logic                      done_o,
	output logic      [NURN_W-1:0]    nurn_o,
	output logic      [MEM_AW-1:0]    rdAddr_o,
	output logic      [MEM_AW-1:0]    wrAddr_o,
	output logic                      memWe_o,
	output logic                      accClr_o,
	output logic                      accEn_o,
	output rclSel_e                   rclSel_o,
	output logic                      cmpTh_o,
	output wrSel_e                    wrSel_o,
	output logic                      rclSpike_o
);

	ctrlState_e        state;
	logic [NURN_W-1:0] nurnCnt;
	logic [AXON_W-1:0] axonCnt;
	logic              lastAxon;
	logic              lastNurn;
	logic [SLOT_W-1:0] rdSlot;
	logic [SLOT_W-1:0] wrSlot;

	assign lastAxon = axonCnt == AXON_W'(NUM_AXONS - 1);
	assign lastNurn = nurnCnt == NURN_W'(NUM_NURNS - 1);

	//--------------------------------------------------------
	// state and counters
	//--------------------------------------------------------
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state   <= ST_IDLE;
			nurnCnt <= '0;
			axonCnt <= '0;
			done_o  <= 1'b0;
		end else begin
			done_o <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (start_i) begin
						state   <= ST_CLR;
						nurnCnt <= '0;
						axonCnt <= '0;
					end
				end
				ST_CLR:    state <= ST_BIAS;
				ST_BIAS:   state <= ST_POT;
				ST_POT:    state <= ST_AXON;
				ST_AXON: begin
					// wraps back to zero after the last axon
					axonCnt <= axonCnt + 1'b1;
					if (lastAxon) begin
						state <= ST_CMP;
					end
				end
				ST_CMP:    state <= ST_WR_POT;
				ST_WR_POT: state <= ST_WR_TH;
				ST_WR_TH:  state <= ST_NEXT;
				ST_NEXT: begin
					if (lastNurn) begin
						state  <= ST_IDLE;
						done_o <= 1'b1;
					end else begin
						state   <= ST_CLR;
						nurnCnt <= nurnCnt + 1'b1;
					end
				end
				default:   state <= ST_IDLE;
			endcase
		end
	end

	//--------------------------------------------------------
	// per-state controls, read address one state ahead
	//--------------------------------------------------------
	always_comb begin
		accClr_o = 1'b0;
		accEn_o  = 1'b0;
		rclSel_o = SEL_WT;
		cmpTh_o  = 1'b0;
		wrSel_o  = WR_POT;
		memWe_o  = 1'b0;
		rdSlot   = SLOT_BIAS;
		wrSlot   = SLOT_POT;
		case (state)
			ST_CLR: begin
				accClr_o = 1'b1;
				rdSlot   = SLOT_BIAS;
			end
			ST_BIAS: begin
				accEn_o  = 1'b1;
				rclSel_o = SEL_BIAS;
				rdSlot   = SLOT_POT;
			end
			ST_POT: begin
				accEn_o  = 1'b1;
				rclSel_o = SEL_POT;
				rdSlot   = SLOT_WT;
			end
			ST_AXON: begin
				accEn_o = 1'b1;
				rdSlot  = lastAxon ? SLOT_TH : SLOT_WT + {1'b0, axonCnt} + 4'd1;
			end
			ST_CMP: cmpTh_o = 1'b1;
			ST_WR_POT: begin
				memWe_o = 1'b1;
				wrSlot  = SLOT_POT;
			end
			ST_WR_TH: begin
				memWe_o = 1'b1;
				wrSel_o = WR_TH;
				wrSlot  = SLOT_TH;
			end
			default: ;
		endcase
	end

	assign rdAddr_o   = {nurnCnt, rdSlot};
	assign wrAddr_o   = {nurnCnt, wrSlot};
	assign nurn_o     = nurnCnt;
	assign busy_o     = state != ST_IDLE;
	assign rclSpike_o = inSpike_i[axonCnt];

endmodule

`default_nettype wire

// File: verilog/dataPath.sv
//------------------------------------------------------------
// dataPath
// saturating recall accumulator, threshold compare, spike
// pulse and the potential / threshold write-back muxes
//------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module dataPath
	import nurnPkg::*;
(
	input  wire logic              clk_i,
	input  wire logic              rst_n_i,
	input  wire logic [DATA_W-1:0] rdData_i,
	input  wire logic              nurnType_i,
	input  wire logic              randTh_i,
	input  wire logic [DATA_W-1:0] rstPot_i,
	input  wire logic [DATA_W-1:0] thMask_i,
	input  wire logic [DATA_W-1:0] lfsrData_i,
	input  wire logic              accClr_i,
	input  wire logic              accEn_i,
	input  wire rclSel_e           rclSel_i,
	input  wire logic              rclSpike_i,
	input  wire logic              cmpTh_i,
	input  wire wrSel_e            wrSel_i,
	input  wire logic [NURN_W-1:0] nurn_i,
	output logic      [DATA_W-1:0] wrData_o,
	output logic                   outSpike_o,
	output logic      [NURN_W-1:0] spikeNurn_o,
	output logic                   rdLfsr_o
);

	logic        [DATA_W-1:0] acc;
	logic        [DATA_W-1:0] accNext;
	logic signed [DATA_W:0]   rdExt;
	logic signed [DATA_W:0]   rclB;
	logic signed [DATA_W:0]   rclSum;
	logic                     cmpGe;
	logic                     spikeR;
	logic        [DATA_W-1:0] thReg;
	logic        [DATA_W:0]   thSum;
	logic        [DATA_W-1:0] thNext;

	//--------------------------------------------------------
	// recall adder
	//--------------------------------------------------------
	assign rdExt = {rdData_i[DATA_W-1], rdData_i};

	always_comb begin
		case (rclSel_i)
			SEL_WT:     rclB = rclSpike_i ? rdExt : '0;
			SEL_BIAS:   rclB = rdExt;
			SEL_POT:    rclB = rdExt;
			SEL_NEG_TH: rclB = -rdExt;
			default:    rclB = '0;
		endcase
	end

	// one extra bit holds any sum, clip when the top two differ
	assign rclSum = $signed({acc[DATA_W-1], acc}) + rclB;

	always_comb begin
		if (rclSum[DATA_W] != rclSum[DATA_W-1]) begin
			accNext = rclSum[DATA_W] ? {1'b1, {(DATA_W-1){1'b0}}} : {1'b0, {(DATA_W-1){1'b1}}};
		end else begin
			accNext = rclSum[DATA_W-1:0];
		end
	end

	assign cmpGe = $signed(acc) >= $signed(rdData_i);

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			acc        <= '0;
			spikeR     <= 1'b0;
			outSpike_o <= 1'b0;
		end else begin
			if (accClr_i) begin
				acc <= '0;
			end else if (accEn_i) begin
				acc <= accNext;
			end
			if (cmpTh_i) begin
				spikeR <= cmpGe;
			end
			// cmpTh lasts one cycle, so this is a pulse
			outSpike_o <= cmpTh_i & cmpGe;
		end
	end

	// threshold and neuron index kept for write-back
	always_ff @(posedge clk_i) begin
		if (cmpTh_i) begin
			thReg       <= rdData_i;
			spikeNurn_o <= nurn_i;
		end
	end

	assign rdLfsr_o = outSpike_o;

	//--------------------------------------------------------
	// write-back
	//--------------------------------------------------------
	// unsigned threshold growth, clipped at all ones
	assign thSum  = {1'b0, thReg} + {1'b0, lfsrData_i & thMask_i};
	assign thNext = thSum[DATA_W] ? '1 : thSum[DATA_W-1:0];

	always_comb begin
		case (wrSel_i)
			WR_POT:  wrData_o = (spikeR && !nurnType_i) ? rstPot_i : acc;
			WR_TH:   wrData_o = (spikeR && randTh_i) ? thNext : thReg;
			default: wrData_o = acc;
		endcase
	end

endmodule

`default_nettype wire

// File: verilog/statusMem.sv
//------------------------------------------------------------
// statusMem
// per-neuron bias, potential, threshold and weights
//------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module statusMem
	import nurnPkg::*;
(
	input  wire logic              clk_i,
	input  wire logic [MEM_AW-1:0] rdAddr_i,
	input  wire logic [MEM_AW-1:0] wrAddr_i,
	input  wire logic [DATA_W-1:0] wrData_i,
	input  wire logic              we_i,
	output logic      [DATA_W-1:0] rdData_o
);

	logic [DATA_W-1:0] mem [2**MEM_AW];

	// registered read, data one cycle after the address
	always_ff @(posedge clk_i) begin
		if (we_i) begin
			mem[wrAddr_i] <= wrData_i;
		end
		rdData_o <= mem[rdAddr_i];
	end

endmodule

`default_nettype wire

// File: verilog/lfsr.sv
//------------------------------------------------------------
// lfsr
// 16-bit Galois LFSR, one step per advance request
//------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module lfsr
	import nurnPkg::*;
(
	input  wire logic              clk_i,
	input  wire logic              rst_n_i,
	input  wire logic              adv_i,
	output logic      [DATA_W-1:0] data_o
);

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			data_o <= LFSR_SEED;
		end else if (adv_i) begin
			// feedback from the bit shifted out
			data_o <= (data_o >> 1) ^ (data_o[0] ? LFSR_TAPS : '0);
		end
	end

endmodule

`default_nettype wire

// File: verilog/nurnPkg.sv
//------------------------------------------------------------
// nurnPkg
// widths, memory map, register offsets and enums shared by
// the spiking-neuron recall core
//------------------------------------------------------------
`default_nettype none

package nurnPkg;

	// signed 8.8 fixed point
	localparam int INT_W     = 8;
	localparam int FRAC_W    = 8;
	localparam int DATA_W    = INT_W + FRAC_W;

	localparam int NUM_NURNS = 4;
	localparam int NURN_W    = 2;
	localparam int NUM_AXONS = 8;
	localparam int AXON_W    = 3;

	// status memory, neuron n owns words n*16 .. n*16+15
	localparam int MEM_AW    = 6;
	localparam int SLOT_W    = 4;
	localparam logic [SLOT_W-1:0] SLOT_BIAS = 4'd0;
	localparam logic [SLOT_W-1:0] SLOT_POT  = 4'd1;
	localparam logic [SLOT_W-1:0] SLOT_TH   = 4'd2;
	localparam logic [SLOT_W-1:0] SLOT_WT   = 4'd8;

	// x^16+x^14+x^13+x^11, right-shifting Galois form
	localparam logic [DATA_W-1:0] LFSR_SEED = 16'hACE1;
	localparam logic [DATA_W-1:0] LFSR_TAPS = 16'hB400;

	//--------------------------------------------------------
	// AXI4-Lite map
	//--------------------------------------------------------
	localparam int AXI_AW = 12;
	localparam int AXI_DW = 32;
	localparam logic [AXI_AW-1:0] REG_CTRL     = 12'h000;
	localparam logic [AXI_AW-1:0] REG_CFG      = 12'h004;
	localparam logic [AXI_AW-1:0] REG_RSTPOT   = 12'h008;
	localparam logic [AXI_AW-1:0] REG_THMASK   = 12'h00C;
	localparam logic [AXI_AW-1:0] REG_INSPIKE  = 12'h010;
	localparam logic [AXI_AW-1:0] REG_OUTSPIKE = 12'h014;
	localparam logic [AXI_AW-1:0] MEM_BASE     = 12'h100;

	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	// recall adder B operand
	typedef enum logic [1:0] {SEL_WT, SEL_BIAS, SEL_POT, SEL_NEG_TH} rclSel_e;

	// write-back source
	typedef enum logic {WR_POT, WR_TH} wrSel_e;

	typedef enum logic [3:0] {
		ST_IDLE, ST_CLR, ST_BIAS, ST_POT, ST_AXON,
		ST_CMP, ST_WR_POT, ST_WR_TH, ST_NEXT
	} ctrlState_e;

endpackage

`default_nettype wire
